/* common/llc_cfg_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// address geometry of the llc front end
// all widths and the line, set and tag types derive from here
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package llc_cfg_pkg;

    // byte address and line offset
    localparam int addr_bits = 16;
    localparam int offset_bits = 4;

    // number of set index bits
    localparam int set_bits = 4;

    localparam int line_bits = addr_bits - offset_bits;
    localparam int tag_bits = line_bits - set_bits;

    // line address, tag in the upper bits and set in the lower
    typedef logic [line_bits-1:0] line_addr_t;

    typedef logic [set_bits-1:0] llc_set_t;

    typedef logic [tag_bits-1:0] llc_tag_t;

endpackage

/* common/llc_msg_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// message types exchanged by the llc front end
// lookup kinds, reset command and the lookup record
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package llc_msg_pkg;

    // what the downstream pipeline should do with a lookup
    typedef enum logic [2:0] {
        k_rst    = 3'd0,
        k_flush  = 3'd1,
        k_rsp    = 3'd2,
        k_req    = 3'd3,
        k_replay = 3'd4,
        k_dma    = 3'd5
    } lookup_kind_t;

    // reset or flush command
    typedef struct packed {
        logic is_flush;
    } rst_cmd_t;

    // registered decoder output
    typedef struct packed {
        lookup_kind_t          kind;
        llc_cfg_pkg::llc_set_t set;
        llc_cfg_pkg::llc_tag_t tag;
    } lookup_t;

endpackage

/* common/llc_stall_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// walk and stall state between decoder and stall controller
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface llc_stall_if;
    import llc_cfg_pkg::*;

    // state held by the stall controller
    logic       walk_active;
    logic       walk_is_flush;
    llc_set_t   walk_set;
    logic       walk_last;
    logic       req_stall;
    logic       replay_pending;
    line_addr_t stalled_line;

    // strobes from the decoder, one decision wide
    logic       start_walk;
    logic       start_is_flush;
    logic       step_walk;
    logic       take_replay;
    logic       clr_stall;

    modport dec (
        input  walk_active, walk_is_flush, walk_set, req_stall, replay_pending, stalled_line,
        output start_walk, start_is_flush, step_walk, take_replay, clr_stall
    );

    modport ctrl (
        output walk_active, walk_is_flush, walk_set, walk_last, req_stall, replay_pending,
        output stalled_line,
        input  start_walk, start_is_flush, step_walk, take_replay, clr_stall
    );

endinterface

/* rtl/llc_in_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// small valid/ready input queue, one per message source
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module llc_in_fifo #(
    parameter type msg_t = logic,
    parameter int FIFO_DEPTH = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    output logic in_ready,
    input  msg_t in_data,
    output logic out_valid,
    output msg_t out_data,
    input  logic take
);

    localparam int ptr_bits = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int cnt_bits = $clog2(FIFO_DEPTH + 1);

    msg_t                mem [FIFO_DEPTH];
    logic [ptr_bits-1:0] wr_ptr;
    logic [ptr_bits-1:0] rd_ptr;
    logic [cnt_bits-1:0] count;
    logic                rst_done;
    logic                push;
    logic                pop;

    // ready stays low until the first edge after reset
    assign in_ready = rst_done && (count != cnt_bits'(FIFO_DEPTH));
    assign out_valid = (count != '0);
    assign out_data = mem[rd_ptr];
    assign push = in_valid && in_ready;
    assign pop = take && out_valid;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rst_done <= 1'b0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            rst_done <= 1'b1;
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_bits'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_bits'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

/* llc_input/llc_input_decoder.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// picks one message per decision by fixed priority and
// registers it as a set/tag lookup for the pipeline
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module llc_input_decoder (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rst_valid,
    input  llc_msg_pkg::rst_cmd_t  rst_data,
    output logic                   rst_take,
    input  logic                   rsp_valid,
    input  llc_cfg_pkg::line_addr_t rsp_line,
    output logic                   rsp_take,
    input  logic                   req_valid,
    input  llc_cfg_pkg::line_addr_t req_line,
    output logic                   req_take,
    input  logic                   dma_valid,
    input  llc_cfg_pkg::line_addr_t dma_line,
    output logic                   dma_take,
    output logic                   lookup_valid,
    input  logic                   lookup_ready,
    output llc_msg_pkg::lookup_t   lookup,
    llc_stall_if.dec               stall
);
    import llc_cfg_pkg::*;
    import llc_msg_pkg::*;

    logic       decode_en;
    logic       req_hazard;
    logic       issue;
    line_addr_t addr_for_split;
    lookup_t    lookup_next;

    // lookup register empty or being taken
    assign decode_en = !lookup_valid || lookup_ready;

    // a request leaving right now may still come back as a miss,
    // so nothing that could pass it is picked in the same decision
    assign req_hazard = lookup_valid && (lookup.kind == k_req || lookup.kind == k_replay);

    always_comb begin
        rst_take = 1'b0;
        rsp_take = 1'b0;
        req_take = 1'b0;
        dma_take = 1'b0;
        stall.start_walk = 1'b0;
        stall.start_is_flush = 1'b0;
        stall.step_walk = 1'b0;
        stall.take_replay = 1'b0;
        stall.clr_stall = 1'b0;
        issue = 1'b0;
        addr_for_split = '0;
        lookup_next.kind = k_rsp;

        if (decode_en) begin
            if (stall.walk_active) begin
                issue = 1'b1;
                stall.step_walk = 1'b1;
                lookup_next.kind = stall.walk_is_flush ? k_flush : k_rst;
                addr_for_split = line_addr_t'(stall.walk_set);
            end else if (rst_valid) begin
                // walk starts here with set 0
                issue = 1'b1;
                rst_take = 1'b1;
                stall.start_walk = 1'b1;
                stall.start_is_flush = rst_data.is_flush;
                lookup_next.kind = rst_data.is_flush ? k_flush : k_rst;
            end else if (rsp_valid) begin
                issue = 1'b1;
                rsp_take = 1'b1;
                lookup_next.kind = k_rsp;
                addr_for_split = rsp_line;
                stall.clr_stall = stall.req_stall && (rsp_line == stall.stalled_line);
            end else if (!stall.req_stall && !req_hazard) begin
                if (stall.replay_pending) begin
                    issue = 1'b1;
                    stall.take_replay = 1'b1;
                    lookup_next.kind = k_replay;
                    addr_for_split = stall.stalled_line;
                end else if (req_valid) begin
                    issue = 1'b1;
                    req_take = 1'b1;
                    lookup_next.kind = k_req;
                    addr_for_split = req_line;
                end else if (dma_valid) begin
                    issue = 1'b1;
                    dma_take = 1'b1;
                    lookup_next.kind = k_dma;
                    addr_for_split = dma_line;
                end
            end
        end

        // set in the low bits, tag above
        lookup_next.set = addr_for_split[set_bits-1:0];
        lookup_next.tag = addr_for_split[line_bits-1:set_bits];
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lookup_valid <= 1'b0;
        end else if (decode_en) begin
            lookup_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (decode_en && issue) begin
            lookup <= lookup_next;
        end
    end

endmodule

/* llc_input/llc_stall_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reset/flush set walk and the parked request of a miss
// updated on the same edge as each decoder decision
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module llc_stall_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       miss,
    input  logic                       lookup_fire,
    input  llc_msg_pkg::lookup_kind_t  lookup_kind,
    input  llc_cfg_pkg::line_addr_t    lookup_line,
    llc_stall_if.ctrl                  stall
);
    import llc_cfg_pkg::*;
    import llc_msg_pkg::*;

    logic park;

    // miss only counts for requests and replays
    assign park = lookup_fire && miss && (lookup_kind == k_req || lookup_kind == k_replay);

    assign stall.walk_last = stall.walk_active && (stall.walk_set == '1);

    // walk over all sets, the command itself already covered set 0
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            stall.walk_active <= 1'b0;
            stall.walk_is_flush <= 1'b0;
            stall.walk_set <= '0;
        end else if (stall.start_walk) begin
            stall.walk_active <= 1'b1;
            stall.walk_is_flush <= stall.start_is_flush;
            stall.walk_set <= llc_set_t'(1);
        end else if (stall.step_walk) begin
            stall.walk_set <= stall.walk_set + 1'b1;
            if (stall.walk_last) begin
                stall.walk_active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            stall.req_stall <= 1'b0;
            stall.replay_pending <= 1'b0;
        end else begin
            if (stall.clr_stall) begin
                stall.req_stall <= 1'b0;
            end
            if (stall.take_replay) begin
                stall.replay_pending <= 1'b0;
            end
            // a fresh miss wins over any clear in the same cycle
            if (park) begin
                stall.req_stall <= 1'b1;
                stall.replay_pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (park) begin
            stall.stalled_line <= lookup_line;
        end
    end

endmodule

/* rtl/llc_front_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// llc input front end: four source queues, decoder and
// stall controller, lookup presented on valid/ready
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module llc_front_top #(
    parameter int FIFO_DEPTH = 2
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       rst_cmd_valid,
    output logic                       rst_cmd_ready,
    input  logic                       rst_cmd_is_flush,
    input  logic                       rsp_valid,
    output logic                       rsp_ready,
    input  llc_cfg_pkg::line_addr_t    rsp_line,
    input  logic                       req_valid,
    output logic                       req_ready,
    input  llc_cfg_pkg::line_addr_t    req_line,
    input  logic                       dma_valid,
    output logic                       dma_ready,
    input  llc_cfg_pkg::line_addr_t    dma_line,
    input  logic                       lookup_ready,
    input  logic                       miss,
    output logic                       lookup_valid,
    output llc_msg_pkg::lookup_kind_t  lookup_kind,
    output llc_cfg_pkg::llc_set_t      lookup_set,
    output llc_cfg_pkg::llc_tag_t      lookup_tag
);
    import llc_cfg_pkg::*;
    import llc_msg_pkg::*;

    rst_cmd_t   rst_cmd_in;
    rst_cmd_t   rst_q_data;
    logic       rst_q_valid, rst_q_take;
    line_addr_t rsp_q_line, req_q_line, dma_q_line;
    logic       rsp_q_valid, rsp_q_take;
    logic       req_q_valid, req_q_take;
    logic       dma_q_valid, dma_q_take;
    lookup_t    lookup;

    llc_stall_if stall_if ();

    assign rst_cmd_in.is_flush = rst_cmd_is_flush;

    llc_in_fifo #(.msg_t(rst_cmd_t), .FIFO_DEPTH(FIFO_DEPTH)) i_rst_fifo (
        .clk, .rst, .in_valid(rst_cmd_valid), .in_ready(rst_cmd_ready), .in_data(rst_cmd_in),
        .out_valid(rst_q_valid), .out_data(rst_q_data), .take(rst_q_take)
    );

    llc_in_fifo #(.msg_t(line_addr_t), .FIFO_DEPTH(FIFO_DEPTH)) i_rsp_fifo (
        .clk, .rst, .in_valid(rsp_valid), .in_ready(rsp_ready), .in_data(rsp_line),
        .out_valid(rsp_q_valid), .out_data(rsp_q_line), .take(rsp_q_take)
    );

    llc_in_fifo #(.msg_t(line_addr_t), .FIFO_DEPTH(FIFO_DEPTH)) i_req_fifo (
        .clk, .rst, .in_valid(req_valid), .in_ready(req_ready), .in_data(req_line),
        .out_valid(req_q_valid), .out_data(req_q_line), .take(req_q_take)
    );

    llc_in_fifo #(.msg_t(line_addr_t), .FIFO_DEPTH(FIFO_DEPTH)) i_dma_fifo (
        .clk, .rst, .in_valid(dma_valid), .in_ready(dma_ready), .in_data(dma_line),
        .out_valid(dma_q_valid), .out_data(dma_q_line), .take(dma_q_take)
    );

    llc_input_decoder i_decoder (
        .clk, .rst,
        .rst_valid(rst_q_valid), .rst_data(rst_q_data), .rst_take(rst_q_take),
        .rsp_valid(rsp_q_valid), .rsp_line(rsp_q_line), .rsp_take(rsp_q_take),
        .req_valid(req_q_valid), .req_line(req_q_line), .req_take(req_q_take),
        .dma_valid(dma_q_valid), .dma_line(dma_q_line), .dma_take(dma_q_take),
        .lookup_valid, .lookup_ready, .lookup,
        .stall(stall_if.dec)
    );

    // parked line rebuilt from the registered tag and set
    llc_stall_ctrl i_stall_ctrl (
        .clk, .rst, .miss,
        .lookup_fire(lookup_valid && lookup_ready),
        .lookup_kind(lookup.kind),
        .lookup_line({lookup.tag, lookup.set}),
        .stall(stall_if.ctrl)
    );

    assign lookup_kind = lookup.kind;
    assign lookup_set = lookup.set;
    assign lookup_tag = lookup.tag;

endmodule

/* sim/llc_front_assert.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lookup hold, single take and stall properties of the decoder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module llc_front_assert (
    input logic                 clk,
    input logic                 rst,
    input logic                 lookup_valid,
    input logic                 lookup_ready,
    input llc_msg_pkg::lookup_t lookup,
    input logic [4:0]           takes,
    input logic                 req_stall,
    input logic                 req_take
);

    int fail_count = 0;

    a_hold: assert property (@(posedge clk) disable iff (!rst)
        lookup_valid && !lookup_ready |=> lookup_valid && $stable(lookup))
        else begin
            $error("lookup changed while held by back-pressure");
            fail_count++;
        end

    // pops and the replay strobe
    a_one_take: assert property (@(posedge clk) disable iff (!rst) $onehot0(takes))
        else begin
            $error("more than one take strobe in a decision");
            fail_count++;
        end

    a_no_req: assert property (@(posedge clk) disable iff (!rst) req_stall |-> !req_take)
        else begin
            $error("request taken while stalled");
            fail_count++;
        end

endmodule

bind llc_input_decoder llc_front_assert i_assert (
    .clk,
    .rst,
    .lookup_valid,
    .lookup_ready,
    .lookup,
    .takes({rst_take, rsp_take, req_take, dma_take, stall.take_replay}),
    .req_stall(stall.req_stall),
    .req_take(req_take || stall.take_replay)
);

/* sim/tb_llc_front.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed testbench for the llc front end
// the downstream pipeline is modeled here
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_llc_front;
    import llc_cfg_pkg::*;
    import llc_msg_pkg::*;

    // rough cycle budget of the six tests
    localparam int test_cycles = 2 * 60 + 40 + 80 + 120 + 200;
    localparam int margin_cycles = 300;

    logic         clk = 1'b0;
    logic         rst = 1'b0;
    logic         rst_cmd_valid = 1'b0;
    logic         rst_cmd_is_flush = 1'b0;
    logic         rsp_valid = 1'b0;
    logic         req_valid = 1'b0;
    logic         dma_valid = 1'b0;
    line_addr_t   rsp_line = '0;
    line_addr_t   req_line = '0;
    line_addr_t   dma_line = '0;
    logic         lookup_ready = 1'b1;
    logic         miss = 1'b0;
    logic         rst_cmd_ready;
    logic         rsp_ready;
    logic         req_ready;
    logic         dma_ready;
    logic         lookup_valid;
    lookup_kind_t lookup_kind;
    llc_set_t     lookup_set;
    llc_tag_t     lookup_tag;

    int           got_kind[$];
    int           got_set[$];
    int           got_tag[$];
    int           errors = 0;
    logic [31:0]  line_rng = 32'd51;
    logic [31:0]  ready_rng = 32'd51;
    logic         ready_random = 1'b0;
    logic         ready_level = 1'b1;
    logic         miss_armed = 1'b0;
    line_addr_t   miss_line = '0;

    llc_front_top #(.FIFO_DEPTH(2)) i_dut (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic line_addr_t next_line();
        line_rng = xorshift32(line_rng);
        return line_rng[line_bits-1:0];
    endfunction

    // set is the low part of the line, tag the rest
    function automatic int set_of(input line_addr_t line);
        return int'(line) % (1 << set_bits);
    endfunction

    function automatic int tag_of(input line_addr_t line);
        return int'(line) >> set_bits;
    endfunction

    // downstream model drives ready and misses one armed request line
    always @(posedge clk) begin
        logic       use_random;
        logic       level;
        logic       armed;
        line_addr_t target;
        use_random = ready_random;
        level = ready_level;
        armed = miss_armed;
        target = miss_line;
        #1;
        ready_rng = xorshift32(ready_rng);
        lookup_ready = use_random ? ready_rng[7] : level;
        miss = armed && lookup_valid && lookup_kind == k_req
            && int'(lookup_set) == set_of(target) && int'(lookup_tag) == tag_of(target);
    end

    always @(posedge clk) begin
        if (rst && lookup_valid && lookup_ready) begin
            got_kind.push_back(int'(lookup_kind));
            got_set.push_back(int'(lookup_set));
            got_tag.push_back(int'(lookup_tag));
        end
    end

    task automatic compare_value(input string name, input int expected, input int actual);
        if (expected !== actual) begin
            errors++;
            $display("Error at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic clear_lookups();
        got_kind.delete();
        got_set.delete();
        got_tag.delete();
    endtask

    task automatic send_rst_cmd(input logic is_flush);
        rst_cmd_valid = 1'b1;
        rst_cmd_is_flush = is_flush;
        do @(posedge clk); while (!rst_cmd_ready);
        #1 rst_cmd_valid = 1'b0;
    endtask

    task automatic send_rsp(input line_addr_t line);
        rsp_valid = 1'b1;
        rsp_line = line;
        do @(posedge clk); while (!rsp_ready);
        #1 rsp_valid = 1'b0;
    endtask

    task automatic send_req(input line_addr_t line);
        req_valid = 1'b1;
        req_line = line;
        do @(posedge clk); while (!req_ready);
        #1 req_valid = 1'b0;
    endtask

    task automatic send_dma(input line_addr_t line);
        dma_valid = 1'b1;
        dma_line = line;
        do @(posedge clk); while (!dma_ready);
        #1 dma_valid = 1'b0;
    endtask

    // waits for n lookups in total, then checks that no extra one follows
    task automatic collect_lookups(input int n, input int max_cycles);
        int waited;
        waited = 0;
        while (got_kind.size() < n && waited < max_cycles) begin
            wait_cycles(1);
            waited++;
        end
        if (got_kind.size() < n) begin
            errors++;
            $display("timed out waiting for %0d lookups, only %0d arrived", n, got_kind.size());
        end
        wait_cycles(8);
        compare_value("lookup count", n, got_kind.size());
    endtask

    task automatic expect_lookup(input int idx, input lookup_kind_t kind, input line_addr_t line);
        compare_value("lookup_kind", int'(kind), got_kind[idx]);
        compare_value("lookup_set", set_of(line), got_set[idx]);
        compare_value("lookup_tag", tag_of(line), got_tag[idx]);
    endtask

    task automatic walk_check(input logic is_flush);
        line_addr_t line;
        line = next_line();
        clear_lookups();
        send_rst_cmd(is_flush);
        // lands in its queue while the walk runs
        send_rsp(line);
        collect_lookups(17, 100);
        for (int i = 0; i < 16; i++) begin
            compare_value("lookup_kind", is_flush ? int'(k_flush) : int'(k_rst), got_kind[i]);
            compare_value("lookup_set", i, got_set[i]);
        end
        expect_lookup(16, k_rsp, line);
    endtask

    task automatic priority_order();
        clear_lookups();
        ready_level = 1'b0;
        wait_cycles(2);
        fork
            send_dma(12'h0d1);
            send_req(12'h0e2);
            send_rsp(12'h0f3);
        join
        wait_cycles(4);
        compare_value("lookup_valid", 1, int'(lookup_valid));
        compare_value("lookup_kind", int'(k_rsp), int'(lookup_kind));
        compare_value("lookup count", 0, got_kind.size());
        ready_level = 1'b1;
        collect_lookups(3, 60);
        expect_lookup(0, k_rsp, 12'h0f3);
        expect_lookup(1, k_req, 12'h0e2);
        expect_lookup(2, k_dma, 12'h0d1);
    endtask

    task automatic address_split();
        line_addr_t lines[20];
        clear_lookups();
        for (int i = 0; i < 20; i++) begin
            lines[i] = next_line();
            send_req(lines[i]);
        end
        collect_lookups(20, 120);
        for (int i = 0; i < 20; i++) begin
            expect_lookup(i, k_req, lines[i]);
        end
    endtask

    task automatic stall_replay();
        clear_lookups();
        miss_line = 12'h3a5;
        miss_armed = 1'b1;
        send_req(12'h3a5);
        collect_lookups(1, 40);
        // request and dma stay parked behind the miss
        // a response to another line keeps them there
        send_req(12'h777);
        send_dma(12'h124);
        send_rsp(12'h0c1);
        collect_lookups(2, 40);
        send_rsp(12'h3a5);
        collect_lookups(6, 60);
        miss_armed = 1'b0;
        expect_lookup(0, k_req, 12'h3a5);
        expect_lookup(1, k_rsp, 12'h0c1);
        expect_lookup(2, k_rsp, 12'h3a5);
        expect_lookup(3, k_replay, 12'h3a5);
        expect_lookup(4, k_req, 12'h777);
        expect_lookup(5, k_dma, 12'h124);
    endtask

    task automatic back_pressure();
        line_addr_t lines[12];
        clear_lookups();
        ready_random = 1'b1;
        for (int i = 0; i < 12; i++) begin
            lines[i] = next_line();
            send_req(lines[i]);
        end
        collect_lookups(12, 200);
        ready_random = 1'b0;
        for (int i = 0; i < 12; i++) begin
            expect_lookup(i, k_req, lines[i]);
        end
    endtask

    initial begin
        #((test_cycles + margin_cycles) * 10);
        $display("watchdog expired, the tests did not finish in time");
        $display("Something failed");
        $finish;
    end

    initial begin
        repeat (4) @(posedge clk);
        #1;
        compare_value("lookup_valid", 0, int'(lookup_valid));
        compare_value("rst_cmd_ready", 0, int'(rst_cmd_ready));
        compare_value("rsp_ready", 0, int'(rsp_ready));
        compare_value("req_ready", 0, int'(req_ready));
        compare_value("dma_ready", 0, int'(dma_ready));
        rst = 1'b1;
        wait_cycles(1);
        compare_value("rst_cmd_ready", 1, int'(rst_cmd_ready));
        compare_value("rsp_ready", 1, int'(rsp_ready));
        compare_value("req_ready", 1, int'(req_ready));
        compare_value("dma_ready", 1, int'(dma_ready));
        walk_check(1'b0);
        walk_check(1'b1);
        priority_order();
        address_split();
        stall_replay();
        back_pressure();
        errors += i_dut.i_decoder.i_assert.fail_count;
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* flist.f */
common/llc_cfg_pkg.sv
common/llc_msg_pkg.sv
common/llc_stall_if.sv
rtl/llc_in_fifo.sv
llc_input/llc_input_decoder.sv
llc_input/llc_stall_ctrl.sv
rtl/llc_front_top.sv
sim/llc_front_assert.sv
sim/tb_llc_front.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_llc_front
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Everything OK

SRCS := $(filter %.sv,$(shell cat $(FLIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	-./$(BIN) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
